// File: hdl/mul_rs_consts.svh
`ifndef MUL_RS_CONSTS_SVH
`define MUL_RS_CONSTS_SVH

// Station geometry
`define RS_ENTRIES 16
`define RS_IDX_W   4

// Physical register tag and instruction address
`define TAG_W      8
`define PC_W       32

`endif

// File: hdl/mul_rs_pkg.sv
`include "mul_rs_consts.svh"

package mul_rs_pkg;

    typedef logic [`TAG_W-1:0]    phys_tag_t;   // Physical register tag
    typedef logic [`PC_W-1:0]     pc_t;
    typedef logic [`RS_IDX_W-1:0] rs_idx_t;     // Entry index, wraps at RS_ENTRIES
    typedef logic [`RS_ENTRIES-1:0] rs_vec_t;   // One bit per entry

    // Holds 0 through RS_ENTRIES
    typedef logic [`RS_IDX_W:0]   rs_count_t;

endpackage

// File: hdl/rs_wakeup.sv
`timescale 1ns/1ns
`include "mul_rs_consts.svh"

module rs_wakeup
    import mul_rs_pkg::*;
(
    input  logic      alu_done,
    input  phys_tag_t alu_tag,
    input  logic      mul_done,
    input  phys_tag_t mul_tag,
    input  logic      div_done,
    input  phys_tag_t div_tag,
    input  logic      mem_read,
    input  phys_tag_t mem_tag,
    input  phys_tag_t src1_tags [`RS_ENTRIES],
    input  phys_tag_t src2_tags [`RS_ENTRIES],
    input  phys_tag_t dispatch_src1,
    input  phys_tag_t dispatch_src2,
    output rs_vec_t   wake1,
    output rs_vec_t   wake2,
    output logic      byp1,
    output logic      byp2
);

    logic [3:0] bc_done;
    phys_tag_t  bc_tag [4];

    // True when any valid broadcast carries this tag
    function automatic logic bus_hit(input phys_tag_t tag, input logic [3:0] done,
                                     input phys_tag_t bus [4]);
        logic hit;
        hit = 1'b0;
        for (int b = 0; b < 4; b++) begin
            hit = hit | (done[b] && (bus[b] == tag));
        end
        return hit;
    endfunction

    always_comb begin
        bc_done   = {mem_read, div_done, mul_done, alu_done};
        bc_tag[0] = alu_tag;
        bc_tag[1] = mul_tag;
        bc_tag[2] = div_tag;
        bc_tag[3] = mem_tag;  // Load result
    end

    always_comb begin
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            wake1[i] = bus_hit(src1_tags[i], bc_done, bc_tag);
            wake2[i] = bus_hit(src2_tags[i], bc_done, bc_tag);
        end
    end

    // Same-cycle bypass for the instruction being dispatched
    always_comb begin
        byp1 = bus_hit(dispatch_src1, bc_done, bc_tag);
        byp2 = bus_hit(dispatch_src2, bc_done, bc_tag);
    end

endmodule

// File: hdl/rs_entry_array.sv
`timescale 1ns/1ns
`include "mul_rs_consts.svh"

module rs_entry_array
    import mul_rs_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  logic      alloc_en,
    input  rs_idx_t   tail,
    input  pc_t       dispatch_pc,
    input  phys_tag_t dispatch_rd,
    input  phys_tag_t dispatch_src1,
    input  phys_tag_t dispatch_src2,
    input  logic      dispatch_rdy1,
    input  logic      dispatch_rdy2,
    input  logic      byp1,
    input  logic      byp2,
    input  rs_vec_t   wake1,
    input  rs_vec_t   wake2,
    input  logic      pick_en,
    input  rs_idx_t   pick_idx,
    output rs_vec_t   busy,
    output rs_vec_t   ready,
    output phys_tag_t src1_tags [`RS_ENTRIES],
    output phys_tag_t src2_tags [`RS_ENTRIES],
    output phys_tag_t rd_tags [`RS_ENTRIES],
    output pc_t       pcs [`RS_ENTRIES]
);

    rs_vec_t rdy1;
    rs_vec_t rdy2;

    // Busy and operand ready state
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            busy <= '0;
            rdy1 <= '0;
            rdy2 <= '0;
        end else begin
            for (int i = 0; i < `RS_ENTRIES; i++) begin
                if (busy[i] && wake1[i]) begin
                    rdy1[i] <= 1'b1;
                end
                if (busy[i] && wake2[i]) begin
                    rdy2[i] <= 1'b1;
                end
            end
            if (pick_en) begin
                busy[pick_idx] <= 1'b0;  // Issued, slot freed
            end
            // Tail slot is never the picked slot, so no ordering conflict
            if (alloc_en) begin
                busy[tail] <= 1'b1;
                rdy1[tail] <= dispatch_rdy1 | byp1;
                rdy2[tail] <= dispatch_rdy2 | byp2;
            end
        end
    end

    // Payload, written only at allocation
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            pcs[tail]       <= dispatch_pc;
            rd_tags[tail]   <= dispatch_rd;
            src1_tags[tail] <= dispatch_src1;
            src2_tags[tail] <= dispatch_src2;
        end
    end

    assign ready = busy & rdy1 & rdy2;

endmodule

// File: hdl/rs_issue_select.sv
`timescale 1ns/1ns
`include "mul_rs_consts.svh"

module rs_issue_select
    import mul_rs_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  rs_idx_t   head,
    input  rs_count_t count,
    input  rs_vec_t   busy,
    input  rs_vec_t   ready,
    input  pc_t       pcs [`RS_ENTRIES],
    input  phys_tag_t rd_tags [`RS_ENTRIES],
    input  phys_tag_t src1_tags [`RS_ENTRIES],
    input  phys_tag_t src2_tags [`RS_ENTRIES],
    output logic      pick_en,
    output rs_idx_t   pick_idx,
    output logic      issue_valid,
    output pc_t       issue_pc,
    output phys_tag_t issue_rd,
    output phys_tag_t issue_src1,
    output phys_tag_t issue_src2
);

    rs_vec_t cand;
    rs_vec_t window;  // Bit k is entry head+k
    rs_idx_t pick_off;

    always_comb begin
        cand = busy & ready;
        for (int k = 0; k < `RS_ENTRIES; k++) begin
            window[k] = cand[rs_idx_t'(head + rs_idx_t'(k))] && (rs_count_t'(k) < count);
        end
    end

    // Lowest offset wins, i.e. oldest
    always_comb begin
        pick_en  = 1'b0;
        pick_off = '0;
        for (int k = `RS_ENTRIES - 1; k >= 0; k--) begin
            if (window[k]) begin
                pick_en  = 1'b1;
                pick_off = rs_idx_t'(k);
            end
        end
    end

    assign pick_idx = head + pick_off;  // Wraps around the buffer

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= pick_en;
        end
    end

    always_ff @(posedge clk) begin
        if (pick_en) begin
            issue_pc   <= pcs[pick_idx];
            issue_rd   <= rd_tags[pick_idx];
            issue_src1 <= src1_tags[pick_idx];
            issue_src2 <= src2_tags[pick_idx];
        end
    end

endmodule

// File: hdl/rs_queue_ctrl.sv
`timescale 1ns/1ns
`include "mul_rs_consts.svh"

module rs_queue_ctrl
    import mul_rs_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  logic      dispatch_valid,
    input  rs_vec_t   busy,
    output logic      alloc_en,
    output rs_idx_t   tail,
    output rs_idx_t   head,
    output rs_count_t count,
    output logic      full
);

    logic head_adv;

    assign full     = (count == rs_count_t'(`RS_ENTRIES));
    assign alloc_en = dispatch_valid && !full;  // Lost when full

    // Head entry already issued, step past it
    assign head_adv = (count != '0) && !busy[head];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc_en) begin
                tail <= tail + 1'b1;
            end
            if (head_adv) begin
                head <= head + 1'b1;
            end
            case ({alloc_en, head_adv})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

endmodule

// File: hdl/mul_rs_top.sv
`timescale 1ns/1ns
`include "mul_rs_consts.svh"

module mul_rs_top
    import mul_rs_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      dispatch_valid,
    input  pc_t       dispatch_pc,
    input  phys_tag_t dispatch_rd,
    input  phys_tag_t dispatch_src1,
    input  phys_tag_t dispatch_src2,
    input  logic      dispatch_rdy1,
    input  logic      dispatch_rdy2,
    input  logic      alu_done,
    input  phys_tag_t alu_tag,
    input  logic      mul_done,
    input  phys_tag_t mul_tag,
    input  logic      div_done,
    input  phys_tag_t div_tag,
    input  logic      mem_read,
    input  phys_tag_t mem_tag,
    input  logic      flush,
    output logic      issue_valid,
    output pc_t       issue_pc,
    output phys_tag_t issue_rd,
    output phys_tag_t issue_src1,
    output phys_tag_t issue_src2,
    output logic      full
);

    logic      alloc_en;
    rs_idx_t   tail;
    rs_idx_t   head;
    rs_count_t count;
    rs_vec_t   busy;
    rs_vec_t   ready;
    rs_vec_t   wake1;
    rs_vec_t   wake2;
    logic      byp1;
    logic      byp2;
    logic      pick_en;
    rs_idx_t   pick_idx;
    phys_tag_t src1_tags [`RS_ENTRIES];
    phys_tag_t src2_tags [`RS_ENTRIES];
    phys_tag_t rd_tags [`RS_ENTRIES];
    pc_t       pcs [`RS_ENTRIES];

    rs_queue_ctrl u_queue_ctrl (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .busy           (busy),
        .alloc_en       (alloc_en),
        .tail           (tail),
        .head           (head),
        .count          (count),
        .full           (full)
    );

    rs_entry_array u_entry_array (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .alloc_en      (alloc_en),
        .tail          (tail),
        .dispatch_pc   (dispatch_pc),
        .dispatch_rd   (dispatch_rd),
        .dispatch_src1 (dispatch_src1),
        .dispatch_src2 (dispatch_src2),
        .dispatch_rdy1 (dispatch_rdy1),
        .dispatch_rdy2 (dispatch_rdy2),
        .byp1          (byp1),
        .byp2          (byp2),
        .wake1         (wake1),
        .wake2         (wake2),
        .pick_en       (pick_en),
        .pick_idx      (pick_idx),
        .busy          (busy),
        .ready         (ready),
        .src1_tags     (src1_tags),
        .src2_tags     (src2_tags),
        .rd_tags       (rd_tags),
        .pcs           (pcs)
    );

    rs_wakeup u_wakeup (
        .alu_done      (alu_done),
        .alu_tag       (alu_tag),
        .mul_done      (mul_done),
        .mul_tag       (mul_tag),
        .div_done      (div_done),
        .div_tag       (div_tag),
        .mem_read      (mem_read),
        .mem_tag       (mem_tag),
        .src1_tags     (src1_tags),
        .src2_tags     (src2_tags),
        .dispatch_src1 (dispatch_src1),
        .dispatch_src2 (dispatch_src2),
        .wake1         (wake1),
        .wake2         (wake2),
        .byp1          (byp1),
        .byp2          (byp2)
    );

    rs_issue_select u_issue_select (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .head        (head),
        .count       (count),
        .busy        (busy),
        .ready       (ready),
        .pcs         (pcs),
        .rd_tags     (rd_tags),
        .src1_tags   (src1_tags),
        .src2_tags   (src2_tags),
        .pick_en     (pick_en),
        .pick_idx    (pick_idx),
        .issue_valid (issue_valid),
        .issue_pc    (issue_pc),
        .issue_rd    (issue_rd),
        .issue_src1  (issue_src1),
        .issue_src2  (issue_src2)
    );

endmodule

// File: dv/mul_rs_chk.sv
`timescale 1ns/1ns
`include "mul_rs_consts.svh"

module mul_rs_chk
    import mul_rs_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      flush,
    input logic      issue_valid,
    input logic      full,
    input rs_idx_t   tail,
    input rs_count_t count
);

    // Cleared entries never reach the issue port
    a_quiet_after_clear: assert property (
        @(posedge clk)
        ($past(reset || flush) || $past(reset || flush, 2)) |-> !issue_valid)
        else $error("issue_valid high within two cycles after reset or flush");

    // Tail steps only on an accept
    a_no_accept_when_full: assert property (
        @(posedge clk) disable iff (reset) (full && !flush) |=> $stable(tail))
        else $error("dispatch accepted while the station is full");

    a_count_bound: assert property (
        @(posedge clk) disable iff (reset) count <= rs_count_t'(`RS_ENTRIES))
        else $error("occupancy count above the entry count");

endmodule

// File: dv/mul_rs_tb.sv
`timescale 1ns/1ns
`include "mul_rs_consts.svh"

module mul_rs_tb
    import mul_rs_pkg::*;
();

    localparam int MAX_CYCLES = 600;

    typedef struct packed {
        logic      busy;
        logic      rdy1;
        logic      rdy2;
        pc_t       pc;
        phys_tag_t rd;
        phys_tag_t src1;
        phys_tag_t src2;
    } slot_t;

    logic      clk = 1'b0;
    logic      reset, flush, dispatch_valid, dispatch_rdy1, dispatch_rdy2;
    pc_t       dispatch_pc;
    phys_tag_t dispatch_rd, dispatch_src1, dispatch_src2;
    logic      alu_done, mul_done, div_done, mem_read;
    phys_tag_t alu_tag, mul_tag, div_tag, mem_tag;
    logic      issue_valid, full;
    pc_t       issue_pc;
    phys_tag_t issue_rd, issue_src1, issue_src2;

    slot_t       model_q [$];  // Reference station in age order, freed slots kept
    slot_t       exp_slot;
    logic        exp_valid;
    logic        exp_full;
    logic [31:0] lfsr_state = 32'hd687;
    int          cycles = 0;

    mul_rs_top u_dut (.*);

    bind mul_rs_top mul_rs_chk u_chk (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_tag(input string name, input phys_tag_t exp, input phys_tag_t act);
        if (act !== exp) begin
            $display("FAILED at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_pc(input string name, input pc_t exp, input pc_t act);
        if (act !== exp) begin
            $display("FAILED at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED at %0t ns: %s expected %b, actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        logic        b;
        val = '0;
        for (int i = 0; i < n; i++) begin
            b          = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            val = {val[30:0], b};
        end
        return val;
    endfunction

    function automatic phys_tag_t rand_tag();
        return phys_tag_t'(lfsr_bits(`TAG_W));
    endfunction

    function automatic logic bcast_hit(input phys_tag_t tag);
        return (alu_done && alu_tag == tag) || (mul_done && mul_tag == tag) ||
               (div_done && div_tag == tag) || (mem_read && mem_tag == tag);
    endfunction

    task automatic idle_inputs();
        dispatch_valid = 1'b0;
        dispatch_rdy1  = 1'b0;
        dispatch_rdy2  = 1'b0;
        dispatch_pc    = '0;
        dispatch_rd    = '0;
        dispatch_src1  = '0;
        dispatch_src2  = '0;
        alu_done       = 1'b0;
        mul_done       = 1'b0;
        div_done       = 1'b0;
        mem_read       = 1'b0;
        alu_tag        = '0;
        mul_tag        = '0;
        div_tag        = '0;
        mem_tag        = '0;
        flush          = 1'b0;
    endtask

    task automatic set_dispatch(input phys_tag_t s1, input logic r1,
                                input phys_tag_t s2, input logic r2);
        dispatch_valid = 1'b1;
        dispatch_pc    = lfsr_bits(`PC_W);
        dispatch_rd    = rand_tag();
        dispatch_src1  = s1;
        dispatch_rdy1  = r1;
        dispatch_src2  = s2;
        dispatch_rdy2  = r2;
    endtask

    // Bus 0 ALU, 1 MUL, 2 DIV, 3 load
    task automatic set_bcast(input int bus, input phys_tag_t tag);
        alu_done = alu_done | (bus == 0);
        alu_tag  = (bus == 0) ? tag : alu_tag;
        mul_done = mul_done | (bus == 1);
        mul_tag  = (bus == 1) ? tag : mul_tag;
        div_done = div_done | (bus == 2);
        div_tag  = (bus == 2) ? tag : div_tag;
        mem_read = mem_read | (bus == 3);
        mem_tag  = (bus == 3) ? tag : mem_tag;
    endtask

    // Applies one clock edge to the reference queue with the inputs now driven
    task automatic model_edge();
        int    pick;
        logic  was_full;
        logic  adv;
        slot_t s;
        pick     = -1;
        was_full = (model_q.size() == `RS_ENTRIES);
        adv      = (model_q.size() != 0) && !model_q[0].busy;
        for (int i = model_q.size() - 1; i >= 0; i--) begin
            if (model_q[i].busy && model_q[i].rdy1 && model_q[i].rdy2) begin
                pick = i;  // Oldest ready wins
            end
        end
        exp_valid = (pick >= 0);
        if (pick >= 0) begin
            exp_slot = model_q[pick];
        end
        for (int i = 0; i < model_q.size(); i++) begin
            s      = model_q[i];
            s.rdy1 = s.rdy1 | (s.busy && bcast_hit(s.src1));
            s.rdy2 = s.rdy2 | (s.busy && bcast_hit(s.src2));
            if (i == pick) begin
                s.busy = 1'b0;
            end
            model_q[i] = s;
        end
        if (adv) begin
            void'(model_q.pop_front());
        end
        if (dispatch_valid && !was_full) begin
            s.busy = 1'b1;
            s.rdy1 = dispatch_rdy1 | bcast_hit(dispatch_src1);
            s.rdy2 = dispatch_rdy2 | bcast_hit(dispatch_src2);
            s.pc   = dispatch_pc;
            s.rd   = dispatch_rd;
            s.src1 = dispatch_src1;
            s.src2 = dispatch_src2;
            model_q.push_back(s);
        end
        if (flush) begin
            model_q.delete();
            exp_valid = 1'b0;
        end
        exp_full = (model_q.size() == `RS_ENTRIES);
    endtask

    task automatic step_cycle();
        model_edge();
        @(posedge clk);
        #1;
        check_bit("issue_valid", exp_valid, issue_valid);
        if (exp_valid) begin
            check_pc("issue_pc", exp_slot.pc, issue_pc);
            check_tag("issue_rd", exp_slot.rd, issue_rd);
            check_tag("issue_src1", exp_slot.src1, issue_src1);
            check_tag("issue_src2", exp_slot.src2, issue_src2);
        end
        check_bit("full", exp_full, full);
        idle_inputs();
    endtask

    task automatic drain();
        while (model_q.size() != 0) begin
            step_cycle();
        end
    endtask

    task automatic test_in_order();
        for (int i = 0; i < 4; i++) begin
            set_dispatch(rand_tag(), 1'b1, rand_tag(), 1'b1);
            step_cycle();
        end
        drain();
    endtask

    task automatic test_wakeup();
        set_dispatch(8'h80, 1'b0, 8'h81, 1'b0);
        step_cycle();
        set_dispatch(8'h82, 1'b0, 8'h83, 1'b0);
        step_cycle();
        set_bcast(0, 8'h7f);  // Nobody waits on this
        step_cycle();
        step_cycle();
        set_bcast(0, 8'h80);
        step_cycle();
        set_bcast(1, 8'h81);
        step_cycle();
        set_bcast(2, 8'h82);
        step_cycle();
        set_bcast(3, 8'h83);  // Load result
        step_cycle();
        drain();
    endtask

    task automatic test_out_of_order();
        set_dispatch(8'h88, 1'b0, rand_tag(), 1'b1);
        step_cycle();
        set_dispatch(rand_tag(), 1'b1, rand_tag(), 1'b1);  // Passes the older one
        step_cycle();
        step_cycle();
        set_bcast(2, 8'h88);
        step_cycle();
        step_cycle();
        for (int i = 0; i < 3; i++) begin
            set_dispatch(8'h89, 1'b0, rand_tag(), 1'b1);
            step_cycle();
        end
        set_bcast(1, 8'h89);  // All three ready at once
        step_cycle();
        drain();
    endtask

    task automatic test_bypass();
        set_dispatch(8'h90, 1'b0, 8'h91, 1'b0);
        set_bcast(0, 8'h90);
        set_bcast(3, 8'h91);
        step_cycle();
        step_cycle();
        drain();
    endtask

    task automatic test_full_flush();
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            set_dispatch(phys_tag_t'(8'ha0 + i), 1'b0, rand_tag(), 1'b1);
            step_cycle();
        end
        set_dispatch(rand_tag(), 1'b1, rand_tag(), 1'b1);  // Dropped
        step_cycle();
        flush = 1'b1;
        step_cycle();
        for (int i = 0; i < `RS_ENTRIES; i += 4) begin
            for (int b = 0; b < 4; b++) begin
                set_bcast(b, phys_tag_t'(8'ha0 + i + b));
            end
            step_cycle();
        end
        step_cycle();
        set_dispatch(rand_tag(), 1'b1, rand_tag(), 1'b1);
        step_cycle();
        step_cycle();
        drain();
    endtask

    initial begin
        idle_inputs();
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        model_q.delete();
        check_bit("issue_valid", 1'b0, issue_valid);
        check_bit("full", 1'b0, full);
        test_in_order();
        test_wakeup();
        test_out_of_order();
        test_bypass();
        test_full_flush();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: project.f
+incdir+hdl
hdl/mul_rs_pkg.sv
hdl/rs_wakeup.sv
hdl/rs_entry_array.sv
hdl/rs_issue_select.sv
hdl/rs_queue_ctrl.sv
hdl/mul_rs_top.sv
dv/mul_rs_chk.sv
dv/mul_rs_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the run by its printed result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module mul_rs_tb -f project.f -o mul_rs_sim &&
./obj_dir/mul_rs_sim | tee /dev/stderr | grep "PASS: all tests" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
